//--- verilog.f
+incdir+common
common/board_io_pkg.sv
verilog/io_decode.sv
verilog/io_execute.sv
uart/uart_transmit.sv
verilog/io_result.sv
verilog/board_io_top.sv
tests/tb_board_io.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the board I/O testbench with Verilator, runs it and checks for the pass message

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot enter project directory"
	exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
	-f verilog.f \
	--top-module tb_board_io \
	-Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/Vtb_board_io)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_output" | grep -qx "TEST PASS"; then
	exit 0
else
	echo "Pass message not found in simulation output"
	exit 1
fi

//--- tests/tb_board_io.sv
// Directed testbench for board_io_top, run through verilog.f by the Verilator script
`include "board_io_consts.svh"

module tb_board_io;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_HALF = 20;
	localparam int BIT_NS = `UART_BAUD_DIVIDE * 2 * CLK_HALF;       // One UART bit in ns
	localparam int FRAME_CLOCKS = `UART_BAUD_DIVIDE * `UART_FRAME_BITS;
	localparam int WATCHDOG_CYCLES = 4 * FRAME_CLOCKS + 1920;      // Four frames plus short tests

	logic clk50;
	logic core_reset;
	logic [31:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [31:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic [17:0] red_led;
	logic [8:0] green_led;
	logic [6:0] hex0;
	logic [6:0] hex1;
	logic [6:0] hex2;
	logic [6:0] hex3;
	logic uart_tx;

	logic [17:0] exp_red;                   // Model of the board registers
	logic [8:0] exp_green;
	logic [6:0] exp_hex0;
	logic [6:0] exp_hex1;
	logic [6:0] exp_hex2;
	logic [6:0] exp_hex3;
	int errors;
	int checks;
	int cycle_count;                        // Rising edges since time zero
	integer seed = 32'h56fae9fd;

	board_io_top i_dut(.clk50, .core_reset, .awaddr, .awvalid, .awready, .wdata, .wvalid,
		.wready, .bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp,
		.rvalid, .rready, .red_led, .green_led, .hex0, .hex1, .hex2, .hex3, .uart_tx);

	initial clk50 = 1'b0;
	always #CLK_HALF clk50 = ~clk50;

	always @(posedge clk50)
		cycle_count <= cycle_count + 1;

	task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// One write, address and data offered together, then wait for the response
	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
		output int accept_cycle);
		logic taken;
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		taken = 1'b0;
		while (!taken)
		begin
			@(negedge clk50);                   // Ready is settled mid-cycle
			taken = awready && wready;
			accept_cycle = cycle_count;
			@(posedge clk50);
			#2;
		end
		awvalid = 1'b0;
		wvalid = 1'b0;
		taken = 1'b0;
		while (!taken)
		begin
			@(negedge clk50);
			taken = bvalid;                     // bready stays high
			if (taken)
				check_word("bresp", 32'(bresp), 32'(`AXI_RESP_OKAY));
			@(posedge clk50);
			#2;
		end
	endtask

	task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
		output int accept_cycle);
		logic taken;
		araddr = addr;
		arvalid = 1'b1;
		taken = 1'b0;
		while (!taken)
		begin
			@(negedge clk50);
			taken = arready;
			accept_cycle = cycle_count;
			@(posedge clk50);
			#2;
		end
		arvalid = 1'b0;
		taken = 1'b0;
		while (!taken)
		begin
			@(negedge clk50);
			taken = rvalid;
			if (taken)
			begin
				data = rdata;
				check_word("rresp", 32'(rresp), 32'(`AXI_RESP_OKAY));
			end
			@(posedge clk50);
			#2;
		end
	endtask

	// Samples each bit in its middle, which falls on a falling clock edge
	task automatic uart_expect(input logic [7:0] exp_byte);
		logic [7:0] got;
		@(negedge uart_tx);
		#(BIT_NS / 2);
		check_word("uart start bit", 32'(uart_tx), 32'd0);
		for (int i = 0; i < 8; i++)
		begin
			#(BIT_NS);
			got[i] = uart_tx;                   // LSB first
		end
		#(BIT_NS);
		check_word("uart stop bit", 32'(uart_tx), 32'd1);
		check_word("uart byte", 32'(got), 32'(exp_byte));
	endtask

	task automatic check_pins();
		check_word("red_led", 32'(red_led), 32'(exp_red));
		check_word("green_led", 32'(green_led), 32'(exp_green));
		check_word("hex0", 32'(hex0), 32'(exp_hex0));
		check_word("hex1", 32'(hex1), 32'(exp_hex1));
		check_word("hex2", 32'(hex2), 32'(exp_hex2));
		check_word("hex3", 32'(hex3), 32'(exp_hex3));
	endtask

	task automatic test_reset_state();
		logic [31:0] data;
		int cyc;
		check_pins();
		check_word("idle uart_tx", 32'(uart_tx), 32'd1);
		axi_read(32'(`IO_UART_STATUS), data, cyc);
		check_word("status after reset", data, 32'd1);     // Transmitter ready
	endtask

	task automatic test_led_writes();
		logic [31:0] offsets [9] = '{`IO_RED_LED, `IO_GREEN_LED, `IO_HEX0, `IO_HEX1,
			`IO_HEX2, `IO_HEX3, `IO_UART_STATUS, `IO_TIMER, 32'h20};
		logic [31:0] data;
		int cyc;
		foreach (offsets[i])
		begin
			data = $random(seed);
			axi_write(offsets[i], data, cyc);
			case (offsets[i])
				`IO_RED_LED: exp_red = data[17:0];
				`IO_GREEN_LED: exp_green = data[8:0];
				`IO_HEX0: exp_hex0 = data[6:0];
				`IO_HEX1: exp_hex1 = data[6:0];
				`IO_HEX2: exp_hex2 = data[6:0];
				`IO_HEX3: exp_hex3 = data[6:0];
				default: ;                      // Status, timer, unmapped change nothing
			endcase
			check_pins();
		end
	endtask

	task automatic test_zero_reads();
		logic [31:0] offsets [10] = '{`IO_RED_LED, `IO_GREEN_LED, `IO_HEX0, `IO_HEX1,
			`IO_HEX2, `IO_HEX3, `IO_UART_DATA, 32'h20, 32'h28, 32'h3C};
		logic [31:0] data;
		int cyc;
		foreach (offsets[i])
		begin
			axi_read(offsets[i], data, cyc);
			check_word($sformatf("read of offset %h", offsets[i]), data, 32'd0);
		end
	endtask

	task automatic test_timer();
		logic [31:0] t1;
		logic [31:0] t2;
		int c1;
		int c2;
		axi_read(32'(`IO_TIMER), t1, c1);
		repeat (7) @(posedge clk50);        // Idle gap between reads
		#2;
		axi_read(32'(`IO_TIMER), t2, c2);
		check_word("timer delta", t2 - t1, 32'(c2 - c1));
	endtask

	task automatic test_uart_single();
		logic [31:0] data;
		logic [31:0] status;
		int cyc;
		data = $random(seed);                   // Upper bits must be ignored
		fork
			begin
				axi_write(32'(`IO_UART_DATA), data, cyc);
				axi_read(32'(`IO_UART_STATUS), status, cyc);
				check_word("status during frame", status, 32'd0);
			end
			uart_expect(data[7:0]);
		join
		@(posedge clk50);                       // Sampler ends mid-cycle
		#2;
	endtask

	task automatic test_uart_back_to_back();
		logic [31:0] d1;
		logic [31:0] d2;
		int c1;
		int c2;
		d1 = $random(seed);
		d2 = $random(seed);
		fork
			begin
				axi_write(32'(`IO_UART_DATA), d1, c1);
				axi_write(32'(`IO_UART_DATA), d2, c2);     // Held off by busy
			end
			begin
				uart_expect(d1[7:0]);
				uart_expect(d2[7:0]);
			end
		join
		checks++;
		if (c2 - c1 < FRAME_CLOCKS)
		begin
			errors++;
			$display("FAILED at %0d ns: second UART write taken %0d cycles after first",
				$time, c2 - c1);
		end
	endtask

	initial
	begin
		core_reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		exp_red = '0;
		exp_green = '0;
		exp_hex0 = '0;
		exp_hex1 = '0;
		exp_hex2 = '0;
		exp_hex3 = '0;
		errors = 0;
		checks = 0;
		cycle_count = 0;
		repeat (10) @(posedge clk50);
		#2;
		core_reset = 1'b0;
		bready = 1'b1;                          // Responses taken at once
		rready = 1'b1;
		test_reset_state();
		test_led_writes();
		test_zero_reads();
		test_timer();
		test_uart_single();
		test_uart_back_to_back();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * 2 * CLK_HALF);
		$display("Timeout after %0d cycles, test sequence did not finish (%0d errors so far)",
			WATCHDOG_CYCLES, errors);
		$display("TEST FAIL");
		$finish;
	end

endmodule

//--- verilog/board_io_top.sv
// Board I/O block as an AXI4-Lite slave driving LEDs, seven-segment digits and UART transmit
`include "board_io_consts.svh"

module board_io_top(
	input                               clk50,
	input                               core_reset,
	input board_io_pkg::io_word_t       awaddr,
	input                               awvalid,
	output logic                        awready,
	input board_io_pkg::io_word_t       wdata,
	input                               wvalid,
	output logic                        wready,
	output logic [`AXI_RESP_BITS-1:0]   bresp,
	output logic                        bvalid,
	input                               bready,
	input board_io_pkg::io_word_t       araddr,
	input                               arvalid,
	output logic                        arready,
	output board_io_pkg::io_word_t      rdata,
	output logic [`AXI_RESP_BITS-1:0]   rresp,
	output logic                        rvalid,
	input                               rready,
	output board_io_pkg::red_led_t      red_led,
	output board_io_pkg::green_led_t    green_led,
	output board_io_pkg::hex_digit_t    hex0,
	output board_io_pkg::hex_digit_t    hex1,
	output board_io_pkg::hex_digit_t    hex2,
	output board_io_pkg::hex_digit_t    hex3,
	output logic                        uart_tx);

	import board_io_pkg::*;

	logic wr_en;
	io_sel_t wr_sel;
	io_word_t wr_data;
	logic rd_en;
	io_sel_t rd_sel;
	io_word_t timer_val;
	logic tx_load;
	logic [7:0] tx_byte;
	logic uart_busy;

	assign bresp = `AXI_RESP_OKAY;      // No error cases
	assign rresp = `AXI_RESP_OKAY;

	io_decode i_decode(.clk50, .core_reset, .awaddr, .awvalid, .awready, .wdata, .wvalid,
		.wready, .araddr, .arvalid, .arready, .bvalid, .rvalid, .uart_busy, .wr_en,
		.wr_sel, .wr_data, .rd_en, .rd_sel);

	io_execute i_execute(.clk50, .core_reset, .wr_en, .wr_sel, .wr_data, .red_led,
		.green_led, .hex0, .hex1, .hex2, .hex3, .timer_val, .tx_load, .tx_byte);

	uart_transmit i_uart_transmit(.clk50, .core_reset, .tx_load, .tx_byte,
		.busy(uart_busy), .uart_tx);

	io_result i_result(.clk50, .core_reset, .wr_en, .rd_en, .rd_sel, .timer_val,
		.uart_busy, .bready, .bvalid, .rready, .rvalid, .rdata);

endmodule

//--- verilog/io_result.sv
// Read data capture and AXI4-Lite response holding for the board I/O slave
module io_result(
	input                               clk50,
	input                               core_reset,
	input                               wr_en,
	input                               rd_en,
	input board_io_pkg::io_sel_t        rd_sel,
	input board_io_pkg::io_word_t       timer_val,
	input                               uart_busy,
	input                               bready,
	output logic                        bvalid,
	input                               rready,
	output logic                        rvalid,
	output board_io_pkg::io_word_t      rdata);

	import board_io_pkg::*;

	// Response flags, held until the master takes them
	always_ff @(posedge clk50, posedge core_reset)
	begin
		if (core_reset)
		begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end
		else
		begin
			if (wr_en)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;

			if (rd_en)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	// Read data sampled at the accepting edge
	always_ff @(posedge clk50)
	begin
		if (rd_en)
		begin
			case (rd_sel)
				SEL_TIMER: rdata <= timer_val;         // Value before this edge
				SEL_UART_STATUS: rdata <= {{($bits(io_word_t) - 1){1'b0}}, !uart_busy};
				default: rdata <= '0;                  // Write-only and unmapped
			endcase
		end
	end

	// Data must not move under a pending response
	assert property (@(posedge clk50) disable iff (core_reset)
		(rvalid && !rready) |=> (rvalid && $stable(rdata)));

endmodule

//--- uart/uart_transmit.sv
// 8N1 serial transmitter with fixed bit period, loaded by io_execute and polled through busy
`include "board_io_consts.svh"

module uart_transmit(
	input               clk50,
	input               core_reset,
	input               tx_load,        // One-cycle start strobe
	input [7:0]         tx_byte,
	output logic        busy,
	output logic        uart_tx);

	localparam int BIT_CLOCKS = `UART_BAUD_DIVIDE;
	localparam int FRAME_BITS = `UART_FRAME_BITS;
	localparam int BAUD_BITS = $clog2(BIT_CLOCKS);
	localparam int COUNT_BITS = $clog2(FRAME_BITS);

	logic [FRAME_BITS-1:0] shift_reg;       // LSB is the bit on the line
	logic [BAUD_BITS-1:0] baud_count;       // Clocks left in current bit
	logic [COUNT_BITS-1:0] bit_count;       // Bits already finished

	always_ff @(posedge clk50, posedge core_reset)
	begin
		if (core_reset)
		begin
			shift_reg <= '1;                    // Line idles high
			baud_count <= '0;
			bit_count <= '0;
			busy <= 1'b0;
		end
		else if (tx_load && !busy)
		begin
			shift_reg <= {1'b1, tx_byte, 1'b0}; // Stop, data LSB first, start
			baud_count <= BAUD_BITS'(BIT_CLOCKS - 1);
			bit_count <= '0;
			busy <= 1'b1;
		end
		else if (busy)
		begin
			if (baud_count == '0)
			begin
				shift_reg <= {1'b1, shift_reg[FRAME_BITS-1:1]};    // Next bit, fill with idle
				baud_count <= BAUD_BITS'(BIT_CLOCKS - 1);
				if (bit_count == COUNT_BITS'(FRAME_BITS - 1))
				begin
					bit_count <= '0;
					busy <= 1'b0;               // Stop bit done
				end
				else
					bit_count <= bit_count + 1'b1;
			end
			else
				baud_count <= baud_count - 1'b1;
		end
	end

	assign uart_tx = shift_reg[0];

	// Decode must hold off data writes during a frame
	assert property (@(posedge clk50) disable iff (core_reset)
		tx_load |-> !busy);

	// A started frame keeps busy for its full length
	assert property (@(posedge clk50) disable iff (core_reset)
		(tx_load && !busy) |=> busy [* (BIT_CLOCKS * FRAME_BITS)] ##1 !busy);

endmodule

//--- verilog/io_execute.sv
// Board LED and digit registers plus free-running timer, written by decoded AXI writes
`include "board_io_consts.svh"

module io_execute(
	input                               clk50,
	input                               core_reset,
	input                               wr_en,
	input board_io_pkg::io_sel_t        wr_sel,
	input board_io_pkg::io_word_t       wr_data,
	output board_io_pkg::red_led_t      red_led,
	output board_io_pkg::green_led_t    green_led,
	output board_io_pkg::hex_digit_t    hex0,
	output board_io_pkg::hex_digit_t    hex1,
	output board_io_pkg::hex_digit_t    hex2,
	output board_io_pkg::hex_digit_t    hex3,
	output board_io_pkg::io_word_t      timer_val,
	output logic                        tx_load,      // Start a UART frame
	output logic [7:0]                  tx_byte);

	import board_io_pkg::*;

	always_ff @(posedge clk50, posedge core_reset)
	begin
		if (core_reset)
		begin
			red_led <= '0;
			green_led <= '0;
			hex0 <= '0;
			hex1 <= '0;
			hex2 <= '0;
			hex3 <= '0;
			timer_val <= '0;
		end
		else
		begin
			timer_val <= timer_val + 1'b1;          // Counts every clock, wraps

			if (wr_en)
			begin
				case (wr_sel)
					SEL_RED_LED: red_led <= wr_data[`RED_LED_BITS-1:0];
					SEL_GREEN_LED: green_led <= wr_data[`GREEN_LED_BITS-1:0];
					SEL_HEX0: hex0 <= wr_data[`HEX_DIGIT_BITS-1:0];
					SEL_HEX1: hex1 <= wr_data[`HEX_DIGIT_BITS-1:0];
					SEL_HEX2: hex2 <= wr_data[`HEX_DIGIT_BITS-1:0];
					SEL_HEX3: hex3 <= wr_data[`HEX_DIGIT_BITS-1:0];
					default:
					begin
						// Status, timer, UART data and unmapped have no register here
					end
				endcase
			end
		end
	end

	// UART data write goes straight to the transmitter
	assign tx_load = wr_en && (wr_sel == SEL_UART_DATA);
	assign tx_byte = wr_data[7:0];                  // Upper bits ignored

endmodule

//--- verilog/io_decode.sv
// Address decode and AXI4-Lite handshake for the board I/O slave, instantiated by board_io_top
`include "board_io_consts.svh"

module io_decode(
	input                           clk50,
	input                           core_reset,
	input board_io_pkg::io_word_t   awaddr,
	input                           awvalid,
	output logic                    awready,
	input board_io_pkg::io_word_t   wdata,
	input                           wvalid,
	output logic                    wready,
	input board_io_pkg::io_word_t   araddr,
	input                           arvalid,
	output logic                    arready,
	input                           bvalid,       // Write response still pending
	input                           rvalid,       // Read response still pending
	input                           uart_busy,
	output logic                    wr_en,
	output board_io_pkg::io_sel_t   wr_sel,
	output board_io_pkg::io_word_t  wr_data,
	output logic                    rd_en,
	output board_io_pkg::io_sel_t   rd_sel);

	import board_io_pkg::*;

	logic uart_blocked;
	logic wr_accept;

	// Low address bits to register select
	function automatic io_sel_t addr_to_sel(input io_word_t addr);
		case (addr[`IO_ADDR_BITS-1:0])
			`IO_RED_LED: return SEL_RED_LED;
			`IO_GREEN_LED: return SEL_GREEN_LED;
			`IO_HEX0: return SEL_HEX0;
			`IO_HEX1: return SEL_HEX1;
			`IO_HEX2: return SEL_HEX2;
			`IO_HEX3: return SEL_HEX3;
			`IO_UART_STATUS: return SEL_UART_STATUS;
			`IO_UART_DATA: return SEL_UART_DATA;
			`IO_TIMER: return SEL_TIMER;
			default: return SEL_NONE;
		endcase
	endfunction

	assign wr_sel = addr_to_sel(awaddr);
	assign wr_data = wdata;
	assign uart_blocked = (wr_sel == SEL_UART_DATA) && uart_busy;   // Back-pressure while sending

	// Address and data are taken together, one write outstanding
	assign wr_accept = awvalid && wvalid && !bvalid && !uart_blocked;
	assign awready = wr_accept;
	assign wready = wr_accept;
	assign wr_en = wr_accept;                       // Target updates at this edge

	// Read path is independent of the write path
	assign rd_sel = addr_to_sel(araddr);
	assign arready = !rvalid;
	assign rd_en = arvalid && arready;

	// No second write while io_result still holds a response
	assert property (@(posedge clk50) disable iff (core_reset)
		awready |-> !bvalid);

	// Same for reads
	assert property (@(posedge clk50) disable iff (core_reset)
		arready |-> !rvalid);

	// Accepted write shows its response next cycle
	assert property (@(posedge clk50) disable iff (core_reset)
		wr_en |=> bvalid);

endmodule

//--- common/board_io_pkg.sv
// Shared types of the board I/O block, imported by the decode, execute and result stages
`include "board_io_consts.svh"

package board_io_pkg;

	// Register addressed by a write or read
	typedef enum logic [3:0]
	{
		SEL_RED_LED,
		SEL_GREEN_LED,
		SEL_HEX0,
		SEL_HEX1,
		SEL_HEX2,
		SEL_HEX3,
		SEL_UART_STATUS,
		SEL_UART_DATA,
		SEL_TIMER,
		SEL_NONE                            // Unmapped or unaligned offset
	} io_sel_t;

	// AXI address and data word
	typedef logic [`IO_WORD_BITS-1:0] io_word_t;

	// Board output registers
	typedef logic [`RED_LED_BITS-1:0] red_led_t;
	typedef logic [`GREEN_LED_BITS-1:0] green_led_t;
	typedef logic [`HEX_DIGIT_BITS-1:0] hex_digit_t;

endpackage

//--- common/board_io_consts.svh
// Register map, field widths and UART timing for the board I/O block, included by RTL and testbench
`ifndef BOARD_IO_CONSTS_SVH
`define BOARD_IO_CONSTS_SVH

// Only the low address bits select a register
`define IO_ADDR_BITS 6

// Register offsets within the I/O window
`define IO_RED_LED 6'h00
`define IO_GREEN_LED 6'h04
`define IO_HEX0 6'h08
`define IO_HEX1 6'h0C
`define IO_HEX2 6'h10
`define IO_HEX3 6'h14
`define IO_UART_STATUS 6'h18    // Bit 0 set when transmitter idle
`define IO_UART_DATA 6'h1C      // Write starts a frame, reads zero
`define IO_TIMER 6'h24

// Board output widths
`define RED_LED_BITS 18
`define GREEN_LED_BITS 9
`define HEX_DIGIT_BITS 7

// AXI data word and response code
`define IO_WORD_BITS 32
`define AXI_RESP_BITS 2
`define AXI_RESP_OKAY 2'b00

// 50 MHz clock, roughly 1.85 Mbaud
`define UART_BAUD_DIVIDE 27
`define UART_FRAME_BITS 10      // Start, eight data, stop

`endif
